// ==== Bender.yml ====
package:
  name: csh_sequencer

sources:
  - include_dirs:
      - src
    files:
      - src/cshTypesPkg.sv
      - src/cshDiagPkg.sv
      - src/cshWayMatch.sv
      - src/cshArbiter.sv
      - src/cshEboxCycle.sv
      - src/cshDiagMux.sv
      - src/cshTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/cshTb.sv

// ==== list.f ====
+incdir+src
src/cshTypesPkg.sv
src/cshDiagPkg.sv
src/cshWayMatch.sv
src/cshArbiter.sv
src/cshEboxCycle.sv
src/cshDiagMux.sv
src/cshTop.sv
tb/cshTb.sv

// ==== src/cshArbiter.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshArbiter (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mbReq,
  input  logic                         chanReq,
  input  logic                         eboxReq,
  input  logic                         ccaReq,
  input  logic                         memBusy,
  input  logic                         coreBusy,
  input  logic                         chanToMem,
  input  logic                         ccaInval,
  input  logic                         ccaValCore,
  input  logic                         anyValidMatch,
  input  logic                         anyWrittenMatch,
  input  logic                         eboxDone,
  input  logic                         writebackT1,
  output cshTypesPkg::cycleTypeT       cycleType,
  output logic                         readyToGo,
  output logic                         eboxStart,
  output logic                         chanWrCache,
  output logic                         ccaInvalDone,
  output logic                         ccaWriteback,
  output logic [`CSH_DIAG_BYTE_W-1:0]  arbStatus
);

  logic mbReqReg;
  logic chanReqEn;
  logic ccaReqEn;
  logic anyGrant;
  logic t0, t1, t2, t3;
  cshTypesPkg::cycleTypeT winner;

  // Fixed priority: MB, channel, EBOX, CCA
  always_comb begin
    winner = cshTypesPkg::cycIdle;
    if (mbReqReg) begin
      winner = cshTypesPkg::cycMb;
    end else if (chanReq && chanReqEn) begin
      winner = cshTypesPkg::cycChan;
    end else if (eboxReq) begin
      winner = cshTypesPkg::cycEbox;
    end else if (ccaReq && ccaReqEn) begin
      winner = cshTypesPkg::cycCca;
    end
  end

  assign anyGrant  = readyToGo && (winner != cshTypesPkg::cycIdle);
  assign eboxStart = anyGrant && (winner == cshTypesPkg::cycEbox);

  always_ff @(posedge clk) begin
    if (reset) begin
      mbReqReg  <= 1'b0;
      chanReqEn <= 1'b0;
      ccaReqEn  <= 1'b0;
    end else begin
      mbReqReg  <= mbReq;
      chanReqEn <= !memBusy && !writebackT1;
      ccaReqEn  <= !coreBusy && !writebackT1;
    end
  end

  // Cycle type holds until the cache is ready again
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleType <= cshTypesPkg::cycIdle;
      readyToGo <= 1'b1;
      t0 <= 1'b0;
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
    end else begin
      // Shared chain for MB, channel and CCA cycles
      t0 <= anyGrant && (winner != cshTypesPkg::cycEbox);
      t1 <= t0;
      t2 <= t1;
      t3 <= t2;
      if (anyGrant) begin
        cycleType <= winner;
        readyToGo <= 1'b0;
      end else if (t3 || eboxDone) begin
        cycleType <= cshTypesPkg::cycIdle;
        readyToGo <= 1'b1;
      end
    end
  end

  assign chanWrCache  = t3 && (cycleType == cshTypesPkg::cycChan) && chanToMem &&
                        anyValidMatch;
  assign ccaInvalDone = t3 && (cycleType == cshTypesPkg::cycCca) && ccaInval &&
                        anyValidMatch && !anyWrittenMatch;
  assign ccaWriteback = t3 && (cycleType == cshTypesPkg::cycCca) && anyWrittenMatch &&
                        ccaValCore;

  always_comb begin
    arbStatus = '0;
    arbStatus[cshDiagPkg::arbCycMbBit]     = cycleType == cshTypesPkg::cycMb;
    arbStatus[cshDiagPkg::arbCycChanBit]   = cycleType == cshTypesPkg::cycChan;
    arbStatus[cshDiagPkg::arbCycEboxBit]   = cycleType == cshTypesPkg::cycEbox;
    arbStatus[cshDiagPkg::arbCycCcaBit]    = cycleType == cshTypesPkg::cycCca;
    arbStatus[cshDiagPkg::arbReadyBit]     = readyToGo;
    arbStatus[cshDiagPkg::arbChanReqEnBit] = chanReqEn;
    arbStatus[cshDiagPkg::arbCcaReqEnBit]  = ccaReqEn;
    arbStatus[cshDiagPkg::arbMbReqBit]     = mbReqReg;
  end

endmodule

// ==== src/cshDiagMux.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshDiagMux (
  input  logic                         diagEn,
  input  cshDiagPkg::diagGroupT        diagSel,
  input  logic [`CSH_DIAG_BYTE_W-1:0]  arbStatus,
  input  logic [`CSH_DIAG_BYTE_W-1:0]  eboxStatus,
  input  logic [`CSH_DIAG_BYTE_W-1:0]  wayStatus,
  output logic [`CSH_DIAG_BYTE_W-1:0]  diagData
);

  always_comb begin
    diagData = '0;
    // Only the low groups are populated
    if (diagEn && (diagSel < `CSH_DIAG_GROUPS)) begin
      case (diagSel)
        cshDiagPkg::grpArb: begin
          diagData = arbStatus;
        end
        cshDiagPkg::grpEbox: begin
          diagData = eboxStatus;
        end
        cshDiagPkg::grpWay: begin
          diagData = wayStatus;
        end
        default: begin
          diagData = '0;
        end
      endcase
    end
  end

endmodule

// ==== src/cshDiagPkg.sv ====
`include "csh_config.svh"

package cshDiagPkg;

  // Groups 3 to 7 read zero
  typedef enum logic [`CSH_DIAG_SEL_W-1:0] {
    grpArb  = 0,
    grpEbox = 1,
    grpWay  = 2
  } diagGroupT;

  // Arbitration byte
  localparam int arbCycMbBit     = 0;
  localparam int arbCycChanBit   = 1;
  localparam int arbCycEboxBit   = 2;
  localparam int arbCycCcaBit    = 3;
  localparam int arbReadyBit     = 4;
  localparam int arbChanReqEnBit = 5;
  localparam int arbCcaReqEnBit  = 6;
  localparam int arbMbReqBit     = 7;

  // EBOX byte
  localparam int eboxT0Bit        = 0;
  localparam int eboxT1Bit        = 1;
  localparam int eboxT2Bit        = 2;
  localparam int eboxT3Bit        = 3;
  localparam int eboxCoreRdBit    = 4;
  localparam int eboxWbPendingBit = 5;
  localparam int eboxRetryBit     = 6;
  localparam int eboxAbortBit     = 7;

  // Way byte, refill way takes two bits
  localparam int wayAnyValidBit   = 0;
  localparam int wayReadFoundBit  = 1;
  localparam int wayAnyWrittenBit = 2;
  localparam int wayLruWrBit      = 3;
  localparam int wayRefillLoBit   = 4;

endpackage

// ==== src/cshEboxCycle.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshEboxCycle (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         eboxStart,
  input  logic                         eboxAbort,
  input  logic                         vmaRead,
  input  logic                         anyValidMatch,
  input  logic                         readFound,
  input  logic                         lruAnyWr,
  input  logic                         coreDataValid,
  output logic                         eboxDone,
  output logic                         writebackT1,
  output logic                         mboxResp,
  output logic                         cacheWr,
  output logic                         eboxWriteback,
  output logic                         eboxRetry,
  output logic                         coreRdReq,
  output logic [`CSH_DIAG_BYTE_W-1:0]  eboxStatus
);

  logic t0, t1, t2, t3;
  logic readHit;
  logic writeHit;
  logic lruWbMiss;
  logic cleanRdMiss;
  logic coreRdDone;
  logic wbPulse;
  logic wbPending;
  logic abortSeen;

  // Outcome terms, sampled at T2
  assign readHit     = vmaRead && readFound;
  assign writeHit    = !vmaRead && anyValidMatch;
  assign lruWbMiss   = !anyValidMatch && lruAnyWr;
  assign cleanRdMiss = vmaRead && !readFound && !lruWbMiss;
  assign coreRdDone  = coreRdReq && coreDataValid;

  always_ff @(posedge clk) begin
    if (reset) begin
      t0 <= 1'b0;
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
      mboxResp <= 1'b0;
      cacheWr <= 1'b0;
      wbPulse <= 1'b0;
      eboxDone <= 1'b0;
      coreRdReq <= 1'b0;
      wbPending <= 1'b0;
      abortSeen <= 1'b0;
    end else begin
      t0 <= eboxStart;
      t1 <= t0;
      // Abort at T1 kills T2
      t2 <= t1 && !eboxAbort;
      t3 <= t2;
      mboxResp <= (t2 && readHit) || coreRdDone;
      cacheWr <= t2 && writeHit;
      wbPulse <= t2 && lruWbMiss;
      eboxDone <= (t1 && eboxAbort) || (t2 && !cleanRdMiss) || coreRdDone;
      // Held until core memory returns the word
      if (t2 && cleanRdMiss) begin
        coreRdReq <= 1'b1;
      end else if (coreDataValid) begin
        coreRdReq <= 1'b0;
      end
      if (eboxStart) begin
        wbPending <= 1'b0;
        abortSeen <= 1'b0;
      end else begin
        if (t2 && lruWbMiss) begin
          wbPending <= 1'b1;
        end
        if (t1 && eboxAbort) begin
          abortSeen <= 1'b1;
        end
      end
    end
  end

  // Writeback of the LRU way forces a retry of the EBOX request
  assign writebackT1   = wbPulse;
  assign eboxWriteback = wbPulse;
  assign eboxRetry     = wbPulse;

  always_comb begin
    eboxStatus = '0;
    eboxStatus[cshDiagPkg::eboxT0Bit]        = t0;
    eboxStatus[cshDiagPkg::eboxT1Bit]        = t1;
    eboxStatus[cshDiagPkg::eboxT2Bit]        = t2;
    eboxStatus[cshDiagPkg::eboxT3Bit]        = t3;
    eboxStatus[cshDiagPkg::eboxCoreRdBit]    = coreRdReq;
    eboxStatus[cshDiagPkg::eboxWbPendingBit] = wbPending;
    eboxStatus[cshDiagPkg::eboxRetryBit]     = eboxRetry;
    eboxStatus[cshDiagPkg::eboxAbortBit]     = abortSeen;
  end

endmodule

// ==== src/cshTop.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshTop (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         mbReq,
  input  logic                         chanReq,
  input  logic                         eboxReq,
  input  logic                         ccaReq,
  input  logic                         memBusy,
  input  logic                         coreBusy,
  input  logic                         chanToMem,
  input  logic                         ccaInval,
  input  logic                         ccaValCore,
  input  logic                         eboxAbort,
  input  logic                         vmaRead,
  input  logic                         coreDataValid,
  input  cshTypesPkg::wayVecT          validMatch,
  input  cshTypesPkg::wayVecT          wordValid,
  input  cshTypesPkg::wayVecT          anyWritten,
  input  cshTypesPkg::wayIdxT          lruSel,
  input  logic                         diagEn,
  input  cshDiagPkg::diagGroupT        diagSel,
  output cshTypesPkg::cycleTypeT       cycleType,
  output logic                         readyToGo,
  output logic                         chanWrCache,
  output logic                         ccaInvalDone,
  output logic                         ccaWriteback,
  output logic                         eboxDone,
  output logic                         mboxResp,
  output logic                         cacheWr,
  output logic                         eboxWriteback,
  output logic                         eboxRetry,
  output logic                         coreRdReq,
  output cshTypesPkg::wayIdxT          refillWay,
  output logic [`CSH_DIAG_BYTE_W-1:0]  diagData
);

  logic anyValidMatch;
  logic readFound;
  logic anyWrittenMatch;
  logic lruAnyWr;
  logic eboxStart;
  logic writebackT1;
  logic [`CSH_DIAG_BYTE_W-1:0] arbStatus;
  logic [`CSH_DIAG_BYTE_W-1:0] eboxStatus;
  logic [`CSH_DIAG_BYTE_W-1:0] wayStatus;

  always_comb begin
    wayStatus = '0;
    wayStatus[cshDiagPkg::wayAnyValidBit]   = anyValidMatch;
    wayStatus[cshDiagPkg::wayReadFoundBit]  = readFound;
    wayStatus[cshDiagPkg::wayAnyWrittenBit] = anyWrittenMatch;
    wayStatus[cshDiagPkg::wayLruWrBit]      = lruAnyWr;
    wayStatus[cshDiagPkg::wayRefillLoBit +: $bits(refillWay)] = refillWay;
  end

  cshWayMatch u_cshWayMatch (
    .validMatch(validMatch),
    .wordValid(wordValid),
    .anyWritten(anyWritten),
    .lruSel(lruSel),
    .anyValidMatch(anyValidMatch),
    .readFound(readFound),
    .anyWrittenMatch(anyWrittenMatch),
    .lruAnyWr(lruAnyWr),
    .refillWay(refillWay)
  );

  cshArbiter u_cshArbiter (
    .clk(clk),
    .reset(reset),
    .mbReq(mbReq),
    .chanReq(chanReq),
    .eboxReq(eboxReq),
    .ccaReq(ccaReq),
    .memBusy(memBusy),
    .coreBusy(coreBusy),
    .chanToMem(chanToMem),
    .ccaInval(ccaInval),
    .ccaValCore(ccaValCore),
    .anyValidMatch(anyValidMatch),
    .anyWrittenMatch(anyWrittenMatch),
    .eboxDone(eboxDone),
    .writebackT1(writebackT1),
    .cycleType(cycleType),
    .readyToGo(readyToGo),
    .eboxStart(eboxStart),
    .chanWrCache(chanWrCache),
    .ccaInvalDone(ccaInvalDone),
    .ccaWriteback(ccaWriteback),
    .arbStatus(arbStatus)
  );

  cshEboxCycle u_cshEboxCycle (
    .clk(clk),
    .reset(reset),
    .eboxStart(eboxStart),
    .eboxAbort(eboxAbort),
    .vmaRead(vmaRead),
    .anyValidMatch(anyValidMatch),
    .readFound(readFound),
    .lruAnyWr(lruAnyWr),
    .coreDataValid(coreDataValid),
    .eboxDone(eboxDone),
    .writebackT1(writebackT1),
    .mboxResp(mboxResp),
    .cacheWr(cacheWr),
    .eboxWriteback(eboxWriteback),
    .eboxRetry(eboxRetry),
    .coreRdReq(coreRdReq),
    .eboxStatus(eboxStatus)
  );

  cshDiagMux u_cshDiagMux (
    .diagEn(diagEn),
    .diagSel(diagSel),
    .arbStatus(arbStatus),
    .eboxStatus(eboxStatus),
    .wayStatus(wayStatus),
    .diagData(diagData)
  );

endmodule

// ==== src/cshTypesPkg.sv ====
`include "csh_config.svh"

package cshTypesPkg;

  // Cycle held in the cycle-type register
  typedef enum logic [2:0] {
    cycIdle,
    cycMb,
    cycChan,
    cycEbox,
    cycCca
  } cycleTypeT;

  // Way number, also used for the LRU select and refill way
  typedef logic [$clog2(`CSH_WAYS)-1:0] wayIdxT;

  // One flag per way
  typedef logic [`CSH_WAYS-1:0] wayVecT;

endpackage

// ==== src/cshWayMatch.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshWayMatch (
  input  cshTypesPkg::wayVecT validMatch,
  input  cshTypesPkg::wayVecT wordValid,
  input  cshTypesPkg::wayVecT anyWritten,
  input  cshTypesPkg::wayIdxT lruSel,
  output logic                anyValidMatch,
  output logic                readFound,
  output logic                anyWrittenMatch,
  output logic                lruAnyWr,
  output cshTypesPkg::wayIdxT refillWay
);

  logic matchSeen;

  assign anyValidMatch   = |validMatch;
  assign readFound       = |(validMatch & wordValid);
  assign anyWrittenMatch = |(validMatch & anyWritten);

  // Written flag of the LRU way, for the writeback decision
  assign lruAnyWr = anyWritten[lruSel];

  // Lowest matching way wins; no match falls back to LRU
  always_comb begin
    matchSeen = 1'b0;
    refillWay = lruSel;
    for (int w = 0; w < `CSH_WAYS; w++) begin
      if (validMatch[w] && !matchSeen) begin
        refillWay = cshTypesPkg::wayIdxT'(w);
        matchSeen = 1'b1;
      end
    end
  end

endmodule

// ==== src/csh_config.svh ====
`ifndef CSH_CONFIG_SVH
`define CSH_CONFIG_SVH

// Cache geometry
`define CSH_WAYS 4

// Diagnostic readback
`define CSH_DIAG_SEL_W 3
`define CSH_DIAG_GROUPS 3
`define CSH_DIAG_BYTE_W 8

`endif

// ==== tb/cshTb.sv ====
`timescale 1ns/100ps
`include "csh_config.svh"

module cshTb;

  localparam int nPrio = 30;
  localparam int nEbox = 24;
  localparam int nNonEbox = 12;
  localparam int nDiag = 16;
  // Cycle budget per phase from the longest path through each task
  localparam int testCycles = 20 + nPrio * 10 + (nEbox + 5) * 20 + (nNonEbox + 2) * 2 * 10 +
                              nDiag * 6;
  localparam int timeoutNs = testCycles * 40 + 2000;

  logic clk = 1'b0;
  logic reset;
  logic mbReq;
  logic chanReq;
  logic eboxReq;
  logic ccaReq;
  logic memBusy;
  logic coreBusy;
  logic chanToMem;
  logic ccaInval;
  logic ccaValCore;
  logic eboxAbort;
  logic vmaRead;
  logic coreDataValid;
  cshTypesPkg::wayVecT validMatch;
  cshTypesPkg::wayVecT wordValid;
  cshTypesPkg::wayVecT anyWritten;
  cshTypesPkg::wayIdxT lruSel;
  logic diagEn;
  cshDiagPkg::diagGroupT diagSel;

  cshTypesPkg::cycleTypeT cycleType;
  logic readyToGo;
  logic chanWrCache;
  logic ccaInvalDone;
  logic ccaWriteback;
  logic eboxDone;
  logic mboxResp;
  logic cacheWr;
  logic eboxWriteback;
  logic eboxRetry;
  logic coreRdReq;
  cshTypesPkg::wayIdxT refillWay;
  logic [`CSH_DIAG_BYTE_W-1:0] diagData;

  int mismatches = 0;
  int failures = 0;
  int chanWrCount = 0;
  int ccaInvCount = 0;
  int ccaWbCount = 0;
  // Expected {mboxResp, cacheWr, eboxWriteback, eboxRetry} per EBOX cycle
  logic [3:0] expQ[$];

  always #10 clk = ~clk;

  cshTop u_cshTop (
    .clk(clk),
    .reset(reset),
    .mbReq(mbReq),
    .chanReq(chanReq),
    .eboxReq(eboxReq),
    .ccaReq(ccaReq),
    .memBusy(memBusy),
    .coreBusy(coreBusy),
    .chanToMem(chanToMem),
    .ccaInval(ccaInval),
    .ccaValCore(ccaValCore),
    .eboxAbort(eboxAbort),
    .vmaRead(vmaRead),
    .coreDataValid(coreDataValid),
    .validMatch(validMatch),
    .wordValid(wordValid),
    .anyWritten(anyWritten),
    .lruSel(lruSel),
    .diagEn(diagEn),
    .diagSel(diagSel),
    .cycleType(cycleType),
    .readyToGo(readyToGo),
    .chanWrCache(chanWrCache),
    .ccaInvalDone(ccaInvalDone),
    .ccaWriteback(ccaWriteback),
    .eboxDone(eboxDone),
    .mboxResp(mboxResp),
    .cacheWr(cacheWr),
    .eboxWriteback(eboxWriteback),
    .eboxRetry(eboxRetry),
    .coreRdReq(coreRdReq),
    .refillWay(refillWay),
    .diagData(diagData)
  );

  task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
    end
  endtask

  task automatic reportFailure(input string what);
    failures++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  function automatic cshTypesPkg::wayVecT randWays();
    return cshTypesPkg::wayVecT'($urandom_range(0, (1 << `CSH_WAYS) - 1));
  endfunction

  // Misses are made more likely than a flat draw would give
  function automatic cshTypesPkg::wayVecT randMatch();
    if ($urandom_range(0, 2) == 0) begin
      return '0;
    end
    return randWays();
  endfunction

  function automatic cshTypesPkg::cycleTypeT refWinner(input logic mb, input logic ch,
                                                       input logic eb, input logic cc,
                                                       input logic memBsy, input logic coreBsy);
    if (mb) begin
      return cshTypesPkg::cycMb;
    end
    if (ch && !memBsy) begin
      return cshTypesPkg::cycChan;
    end
    if (eb) begin
      return cshTypesPkg::cycEbox;
    end
    if (cc && !coreBsy) begin
      return cshTypesPkg::cycCca;
    end
    return cshTypesPkg::cycIdle;
  endfunction

  function automatic logic [`CSH_DIAG_BYTE_W-1:0] refWayByte(input cshTypesPkg::wayVecT vm,
                                                             input cshTypesPkg::wayVecT wv,
                                                             input cshTypesPkg::wayVecT aw,
                                                             input cshTypesPkg::wayIdxT lru);
    logic [`CSH_DIAG_BYTE_W-1:0] b;
    cshTypesPkg::wayIdxT refill;
    b = '0;
    refill = lru;
    // Scan from the top so the lowest match is kept
    for (int w = `CSH_WAYS - 1; w >= 0; w--) begin
      if (vm[w]) begin
        b[cshDiagPkg::wayAnyValidBit] = 1'b1;
        b[cshDiagPkg::wayReadFoundBit] |= wv[w];
        b[cshDiagPkg::wayAnyWrittenBit] |= aw[w];
        refill = cshTypesPkg::wayIdxT'(w);
      end
    end
    b[cshDiagPkg::wayLruWrBit] = aw[lru];
    b[cshDiagPkg::wayRefillLoBit +: $bits(refill)] = refill;
    return b;
  endfunction

  // Returns {coreRead, mboxResp, cacheWr, eboxWriteback, eboxRetry}
  function automatic logic [4:0] refEbox(input logic rd, input logic abort,
                                         input cshTypesPkg::wayVecT vm,
                                         input cshTypesPkg::wayVecT wv,
                                         input cshTypesPkg::wayVecT aw,
                                         input cshTypesPkg::wayIdxT lru);
    logic [`CSH_DIAG_BYTE_W-1:0] s;
    s = refWayByte(vm, wv, aw, lru);
    if (abort) begin
      return 5'b00000;
    end
    if (!s[cshDiagPkg::wayAnyValidBit] && s[cshDiagPkg::wayLruWrBit]) begin
      return 5'b00011;
    end
    if (rd) begin
      return s[cshDiagPkg::wayReadFoundBit] ? 5'b01000 : 5'b11000;
    end
    return s[cshDiagPkg::wayAnyValidBit] ? 5'b00100 : 5'b00000;
  endfunction

  // EBOX byte between cycles, when the chain and the strobes are quiet
  function automatic logic [`CSH_DIAG_BYTE_W-1:0] refEboxByte(input logic wbPend,
                                                              input logic abortSeen);
    logic [`CSH_DIAG_BYTE_W-1:0] b;
    b = '0;
    b[cshDiagPkg::eboxWbPendingBit] = wbPend;
    b[cshDiagPkg::eboxAbortBit] = abortSeen;
    return b;
  endfunction

  // Returns {chanWrCache, ccaInvalDone, ccaWriteback}
  function automatic logic [2:0] refNonEbox(input cshTypesPkg::cycleTypeT kind,
                                            input logic toMem, input logic inval,
                                            input logic valCore, input cshTypesPkg::wayVecT vm,
                                            input cshTypesPkg::wayVecT aw);
    logic hit;
    logic dirtyHit;
    hit = |vm;
    dirtyHit = |(vm & aw);
    if (kind == cshTypesPkg::cycChan) begin
      return {toMem && hit, 2'b00};
    end
    return {1'b0, inval && hit && !dirtyHit, dirtyHit && valCore};
  endfunction

  function automatic logic [`CSH_DIAG_BYTE_W-1:0] refArbByte(input cshTypesPkg::cycleTypeT ct,
                                                             input logic ready,
                                                             input logic chanEn,
                                                             input logic ccaEn,
                                                             input logic mbReg);
    logic [`CSH_DIAG_BYTE_W-1:0] b;
    b = '0;
    b[cshDiagPkg::arbCycMbBit] = ct == cshTypesPkg::cycMb;
    b[cshDiagPkg::arbCycChanBit] = ct == cshTypesPkg::cycChan;
    b[cshDiagPkg::arbCycEboxBit] = ct == cshTypesPkg::cycEbox;
    b[cshDiagPkg::arbCycCcaBit] = ct == cshTypesPkg::cycCca;
    b[cshDiagPkg::arbReadyBit] = ready;
    b[cshDiagPkg::arbChanReqEnBit] = chanEn;
    b[cshDiagPkg::arbCcaReqEnBit] = ccaEn;
    b[cshDiagPkg::arbMbReqBit] = mbReg;
    return b;
  endfunction

  // Compares each EBOX cycle end against its queued outcome
  always @(negedge clk) begin
    if (!reset) begin
      chanWrCount += chanWrCache;
      ccaInvCount += ccaInvalDone;
      ccaWbCount += ccaWriteback;
      if (eboxDone) begin
        if (expQ.size() == 0) begin
          reportFailure("eboxDone pulsed with no EBOX cycle pending");
        end else begin
          checkVal({mboxResp, cacheWr, eboxWriteback, eboxRetry}, expQ.pop_front(),
                   "EBOX outcome strobes");
        end
      end else if (mboxResp || cacheWr || eboxWriteback || eboxRetry) begin
        reportFailure("EBOX outcome strobe pulsed without eboxDone");
      end
    end
  end

  task automatic waitCycleType(input cshTypesPkg::cycleTypeT kind);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (cycleType != kind && n < 8);
    if (cycleType != kind) begin
      reportFailure($sformatf("cycle type %s was never loaded", kind.name()));
    end
  endtask

  task automatic waitReady(output int lat);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!readyToGo && lat < 12);
    if (!readyToGo) begin
      reportFailure("readyToGo did not come back after the cycle");
    end
  endtask

  task automatic runPriority();
    logic mb;
    logic ch;
    logic eb;
    logic cc;
    logic mBsy;
    logic cBsy;
    cshTypesPkg::cycleTypeT exp;
    int lat;
    mb = $urandom_range(0, 3) == 0;
    ch = $urandom_range(0, 1);
    eb = $urandom_range(0, 1);
    cc = $urandom_range(0, 1);
    mBsy = $urandom_range(0, 1);
    cBsy = $urandom_range(0, 1);
    exp = refWinner(mb, ch, eb, cc, mBsy, cBsy);
    // Busy flags and MB request first so the registered copies settle
    @(posedge clk);
    memBusy <= mBsy;
    coreBusy <= cBsy;
    mbReq <= mb;
    @(posedge clk);
    chanReq <= ch;
    eboxReq <= eb;
    ccaReq <= cc;
    @(negedge clk);
    checkVal(readyToGo, 1'b1, "readyToGo before grant");
    @(posedge clk);
    mbReq <= 1'b0;
    chanReq <= 1'b0;
    eboxReq <= 1'b0;
    ccaReq <= 1'b0;
    @(negedge clk);
    checkVal(cycleType, exp, "granted cycle type");
    checkVal(readyToGo, exp == cshTypesPkg::cycIdle, "readyToGo after grant");
    if (exp == cshTypesPkg::cycEbox) begin
      expQ.push_back(4'b0000);
    end
    if (exp != cshTypesPkg::cycIdle) begin
      waitReady(lat);
      checkVal(lat, 4, "cycles from T0 to readyToGo after grant");
    end
  endtask

  task automatic runEbox(input logic rd, input logic abort, input cshTypesPkg::wayVecT vm,
                         input cshTypesPkg::wayVecT wv, input cshTypesPkg::wayVecT aw,
                         input cshTypesPkg::wayIdxT lru);
    logic [4:0] exp;
    int lat;
    int hold;
    exp = refEbox(rd, abort, vm, wv, aw, lru);
    @(posedge clk);
    vmaRead <= rd;
    eboxAbort <= abort;
    validMatch <= vm;
    wordValid <= wv;
    anyWritten <= aw;
    lruSel <= lru;
    eboxReq <= 1'b1;
    waitCycleType(cshTypesPkg::cycEbox);
    expQ.push_back(exp[3:0]);
    @(posedge clk);
    eboxReq <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!eboxDone && !coreRdReq && lat < 8);
    // One cycle shorter on abort
    checkVal(lat, abort ? 2 : 3, "EBOX cycles from T0 to outcome");
    checkVal(coreRdReq, exp[4], "coreRdReq after T2");
    if (coreRdReq) begin
      hold = $urandom_range(0, 5);
      repeat (hold) begin
        @(negedge clk);
        checkVal(coreRdReq, 1'b1, "coreRdReq held while core is busy");
      end
      @(posedge clk);
      coreDataValid <= 1'b1;
      @(posedge clk);
      coreDataValid <= 1'b0;
      @(negedge clk);
      checkVal(eboxDone, 1'b1, "eboxDone one cycle after coreDataValid");
      checkVal(coreRdReq, 1'b0, "coreRdReq cleared by coreDataValid");
    end
    @(negedge clk);
    checkVal(readyToGo, 1'b1, "readyToGo after eboxDone");
    if (exp[1]) begin
      checkVal(diagData[cshDiagPkg::arbChanReqEnBit], 1'b0, "chanReqEn after writeback");
      checkVal(diagData[cshDiagPkg::arbCcaReqEnBit], 1'b0, "ccaReqEn after writeback");
    end
    @(posedge clk);
    diagSel <= cshDiagPkg::grpEbox;
    @(negedge clk);
    checkVal(diagData, refEboxByte(exp[1], abort), "EBOX status byte after cycle");
    @(posedge clk);
    diagSel <= cshDiagPkg::grpArb;
  endtask

  task automatic runNonEbox(input cshTypesPkg::cycleTypeT kind, input logic toMem,
                            input logic inval, input logic valCore,
                            input cshTypesPkg::wayVecT vm, input cshTypesPkg::wayVecT aw);
    logic [2:0] exp;
    int c0;
    int c1;
    int c2;
    int lat;
    exp = refNonEbox(kind, toMem, inval, valCore, vm, aw);
    @(posedge clk);
    chanToMem <= toMem;
    ccaInval <= inval;
    ccaValCore <= valCore;
    validMatch <= vm;
    anyWritten <= aw;
    chanReq <= kind == cshTypesPkg::cycChan;
    ccaReq <= kind == cshTypesPkg::cycCca;
    waitCycleType(kind);
    c0 = chanWrCount;
    c1 = ccaInvCount;
    c2 = ccaWbCount;
    @(posedge clk);
    chanReq <= 1'b0;
    ccaReq <= 1'b0;
    waitReady(lat);
    checkVal(lat, 4, "T0 to readyToGo for non-EBOX cycle");
    checkVal(chanWrCount - c0, exp[2], "chanWrCache pulses");
    checkVal(ccaInvCount - c1, exp[1], "ccaInvalDone pulses");
    checkVal(ccaWbCount - c2, exp[0], "ccaWriteback pulses");
  endtask

  task automatic runDiag();
    cshTypesPkg::wayVecT vm;
    cshTypesPkg::wayVecT wv;
    cshTypesPkg::wayVecT aw;
    cshTypesPkg::wayIdxT lru;
    logic [`CSH_DIAG_BYTE_W-1:0] exp;
    vm = randMatch();
    wv = randWays();
    aw = randWays();
    lru = cshTypesPkg::wayIdxT'($urandom_range(0, `CSH_WAYS - 1));
    exp = refWayByte(vm, wv, aw, lru);
    @(posedge clk);
    validMatch <= vm;
    wordValid <= wv;
    anyWritten <= aw;
    lruSel <= lru;
    diagEn <= 1'b1;
    diagSel <= cshDiagPkg::grpWay;
    @(negedge clk);
    checkVal(diagData, exp, "way status byte");
    checkVal(refillWay, exp[cshDiagPkg::wayRefillLoBit +: $clog2(`CSH_WAYS)], "refillWay");
    @(posedge clk);
    diagSel <= cshDiagPkg::diagGroupT'($urandom_range(3, 7));
    @(negedge clk);
    checkVal(diagData, 0, "unused diagnostic group");
    @(posedge clk);
    diagEn <= 1'b0;
    diagSel <= cshDiagPkg::diagGroupT'($urandom_range(0, 7));
    @(negedge clk);
    checkVal(diagData, 0, "diagnostic read with diagEn low");
    @(posedge clk);
    diagEn <= 1'b1;
    diagSel <= cshDiagPkg::grpArb;
    @(negedge clk);
    checkVal(diagData, refArbByte(cshTypesPkg::cycIdle, 1'b1, 1'b1, 1'b1, 1'b0),
             "idle arbitration byte");
  endtask

  initial begin
    void'($urandom(32'h6dd944b7));
    reset <= 1'b1;
    mbReq <= 1'b0;
    chanReq <= 1'b0;
    eboxReq <= 1'b0;
    ccaReq <= 1'b0;
    memBusy <= 1'b0;
    coreBusy <= 1'b0;
    chanToMem <= 1'b0;
    ccaInval <= 1'b0;
    ccaValCore <= 1'b0;
    eboxAbort <= 1'b0;
    vmaRead <= 1'b0;
    coreDataValid <= 1'b0;
    validMatch <= '0;
    wordValid <= '0;
    anyWritten <= '0;
    lruSel <= '0;
    diagEn <= 1'b1;
    diagSel <= cshDiagPkg::grpArb;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkVal(cycleType, cshTypesPkg::cycIdle, "cycleType after reset");
    checkVal(coreRdReq, 1'b0, "coreRdReq after reset");
    checkVal(diagData, refArbByte(cshTypesPkg::cycIdle, 1'b1, 1'b0, 1'b0, 1'b0),
             "arbitration byte after reset");
    @(negedge clk);
    checkVal(diagData, refArbByte(cshTypesPkg::cycIdle, 1'b1, 1'b1, 1'b1, 1'b0),
             "arbitration byte after first enable update");

    repeat (nPrio) runPriority();
    @(posedge clk);
    memBusy <= 1'b0;
    coreBusy <= 1'b0;
    repeat (nDiag) runDiag();

    // Read hit, write hit, clean read miss, dirty LRU miss, abort
    runEbox(1'b1, 1'b0, 4'b0100, 4'b0100, 4'b0000, 2'd1);
    runEbox(1'b0, 1'b0, 4'b0010, 4'b0000, 4'b0000, 2'd0);
    runEbox(1'b1, 1'b0, 4'b0000, 4'b0000, 4'b0000, 2'd2);
    runEbox(1'b0, 1'b0, 4'b0000, 4'b0000, 4'b1000, 2'd3);
    runEbox(1'b1, 1'b1, 4'b0001, 4'b0001, 4'b0000, 2'd0);
    repeat (nEbox) begin
      runEbox($urandom_range(0, 1), $urandom_range(0, 5) == 0, randMatch(), randWays(),
              randWays(), cshTypesPkg::wayIdxT'($urandom_range(0, `CSH_WAYS - 1)));
    end

    runNonEbox(cshTypesPkg::cycChan, 1'b1, 1'b0, 1'b0, 4'b0001, 4'b0000);
    runNonEbox(cshTypesPkg::cycCca, 1'b0, 1'b1, 1'b0, 4'b0010, 4'b0000);
    runNonEbox(cshTypesPkg::cycCca, 1'b0, 1'b0, 1'b1, 4'b0100, 4'b0100);
    repeat (nNonEbox) begin
      runNonEbox(cshTypesPkg::cycChan, $urandom_range(0, 1), 1'b0, 1'b0, randMatch(),
                 randWays());
      runNonEbox(cshTypesPkg::cycCca, 1'b0, $urandom_range(0, 1), $urandom_range(0, 1),
                 randMatch(), randWays());
    end

    repeat (2) @(negedge clk);
    if (expQ.size() != 0) begin
      reportFailure("EBOX cycles still waiting for eboxDone at end of run");
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeoutNs);
    $display("Timeout: the run did not finish within %0d ns", timeoutNs);
    $display("** FAIL **");
    $finish;
  end

endmodule
